//--- compile.f
hw/cpu_pkg.sv
hw/mem_map_pkg.sv
hw/stage_ifs.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/memory.sv
hw/hazard_unit.sv
hw/cpu.sv
+incdir+tests
tests/cpu_tb.sv

//--- hw/cpu.sv
module cpu (
	input logic clk,
	input logic reset,
	input logic debug,
	input logic [31:0] boot_addr,
	input logic [31:0] boot_data,
	input logic [31:0] joystick_data,
	output logic [31:0] mem_mapped_addr,
	output logic [31:0] mem_mapped_data_out,
	output logic io_store,
	output logic halt
);
	logic stall, flush_ifid, fetch_stop, take_branch, is_branch;
	logic [31:0] branch_pc, ifid_pc, ifid_instr, fetch_instr;
	logic [4:0] rs1, rs2;
	logic wb_we;
	logic [4:0] wb_rd;
	logic [31:0] wb_data;
	logic [31:0] exmem_result;
	logic [4:0] exmem_rd;
	logic exmem_reg_write;

	idex_if idex ();
	exmem_if exmem ();

	fetch fetch_i (
		.clk, .reset, .debug, .stall, .flush_ifid, .fetch_stop, .take_branch,
		.branch_pc, .boot_addr, .boot_data, .ifid_pc, .ifid_instr, .fetch_instr
	);

	decode decode_i (
		.clk, .reset, .debug, .stall, .ifid_pc, .ifid_instr, .wb_we, .wb_rd, .wb_data,
		.exmem_result, .exmem_rd, .exmem_reg_write, .rs1, .rs2, .is_branch,
		.take_branch, .branch_pc, .idex(idex.src)
	);

	execute execute_i (
		.clk, .reset, .debug, .wb_we, .wb_rd, .wb_data,
		.idex(idex.dst), .exmem(exmem.src)
	);

	memory memory_i (
		.clk, .reset, .debug, .boot_addr, .boot_data, .joystick_data, .exmem(exmem.dst),
		.wb_we, .wb_rd, .wb_data, .exmem_result, .exmem_rd, .exmem_reg_write,
		.io_store, .mem_mapped_addr, .mem_mapped_data_out, .halt
	);

	hazard_unit hazard_i (
		.fetch_instr, .rs1, .rs2, .is_branch, .take_branch, .idex(idex.dst),
		.stall, .flush_ifid, .fetch_stop
	);
endmodule

//--- hw/cpu_pkg.sv
package cpu_pkg;
	localparam int xlen = 32;

	// Major opcodes
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_system = 7'b1110011;

	// Function codes
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;
	localparam logic [6:0] f7_sub = 7'b0100000;

	localparam logic [3:0] alu_add = 4'd0;
	localparam logic [3:0] alu_sub = 4'd1;
	localparam logic [3:0] alu_and = 4'd2;
	localparam logic [3:0] alu_or = 4'd3;
	localparam logic [3:0] alu_xor = 4'd4;
	localparam logic [3:0] alu_slt = 4'd5;
	localparam logic [3:0] alu_pass_b = 4'd6;

	// ADDI x0, x0, 0
	localparam logic [31:0] nop_word = 32'h0000_0013;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm_20;
		logic [9:0] imm_10_1;
		logic imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_u;
endpackage

//--- hw/decode.sv
module decode (
	input logic clk,
	input logic reset,
	input logic debug,
	input logic stall,
	input logic [31:0] ifid_pc,
	input logic [31:0] ifid_instr,
	input logic wb_we,
	input logic [4:0] wb_rd,
	input logic [31:0] wb_data,
	input logic [31:0] exmem_result,
	input logic [4:0] exmem_rd,
	input logic exmem_reg_write,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic is_branch,
	output logic take_branch,
	output logic [31:0] branch_pc,
	idex_if.src idex
);
	cpu_pkg::instr_u ins;
	logic [31:0] rf [32];
	logic [31:0] op1, op2, imm, imm_b, imm_j;
	logic [3:0] alu_op;
	logic use_rs1, use_rs2, use_imm, use_pc, link;
	logic mem_read, mem_write, reg_write, ecall, is_jal, equal;

	function automatic logic [31:0] read_reg(input logic [4:0] r);
		if (r == 5'd0) return '0;
		// Newest producer first, then write-first register file
		if (exmem_reg_write && exmem_rd == r) return exmem_result;
		if (wb_we && wb_rd == r) return wb_data;
		return rf[r];
	endfunction

	assign ins = ifid_instr;
	assign rs1 = use_rs1 ? ins.r.rs1 : 5'd0;
	assign rs2 = use_rs2 ? ins.r.rs2 : 5'd0;

	always_ff @(posedge clk) begin
		if (wb_we && wb_rd != 5'd0) begin
			rf[wb_rd] <= wb_data;
		end
	end

	assign imm_b = {{20{ins.b.imm_12}}, ins.b.imm_11, ins.b.imm_10_5, ins.b.imm_4_1, 1'b0};
	assign imm_j = {{12{ins.j.imm_20}}, ins.j.imm_19_12, ins.j.imm_11, ins.j.imm_10_1, 1'b0};

	always_comb begin
		{use_rs1, use_rs2, use_imm, use_pc, link} = '0;
		{mem_read, mem_write, reg_write, ecall, is_branch, is_jal} = '0;
		alu_op = cpu_pkg::alu_add;
		imm = {{20{ins.i.imm_11_0[11]}}, ins.i.imm_11_0};
		case (ins.r.opcode)
			cpu_pkg::op_reg, cpu_pkg::op_imm: begin
				use_rs1 = 1'b1;
				use_rs2 = ins.r.opcode == cpu_pkg::op_reg;
				use_imm = !use_rs2;
				reg_write = 1'b1;
				case (ins.r.funct3)
					cpu_pkg::f3_slt: alu_op = cpu_pkg::alu_slt;
					cpu_pkg::f3_xor: alu_op = cpu_pkg::alu_xor;
					cpu_pkg::f3_or: alu_op = cpu_pkg::alu_or;
					cpu_pkg::f3_and: alu_op = cpu_pkg::alu_and;
					default: begin
						if (use_rs2 && ins.r.funct7 == cpu_pkg::f7_sub) alu_op = cpu_pkg::alu_sub;
					end
				endcase
			end
			cpu_pkg::op_lui: begin
				use_imm = 1'b1;
				reg_write = 1'b1;
				alu_op = cpu_pkg::alu_pass_b;
				imm = {ins.u.imm_31_12, 12'd0};
			end
			cpu_pkg::op_load: begin
				{use_rs1, use_imm, mem_read, reg_write} = '1;
			end
			cpu_pkg::op_store: begin
				{use_rs1, use_rs2, use_imm, mem_write} = '1;
				imm = {{20{ins.s.imm_11_5[6]}}, ins.s.imm_11_5, ins.s.imm_4_0};
			end
			cpu_pkg::op_branch: {use_rs1, use_rs2, is_branch} = '1;
			// Link value is pc plus 4 from the ALU
			cpu_pkg::op_jal: {use_pc, link, reg_write, is_jal} = '1;
			cpu_pkg::op_system: ecall = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		op1 = read_reg(rs1);
		op2 = read_reg(rs2);
	end

	assign equal = op1 == op2;
	assign take_branch = is_jal || (is_branch && ((ins.b.funct3 == cpu_pkg::f3_beq && equal)
		|| (ins.b.funct3 == cpu_pkg::f3_bne && !equal)));
	assign branch_pc = ifid_pc + (is_jal ? imm_j : imm_b);

	always_ff @(posedge clk) begin
		if (reset || debug || stall) begin
			idex.valid <= 1'b0;
			{idex.mem_read, idex.mem_write, idex.reg_write, idex.ecall} <= '0;
		end else begin
			idex.valid <= 1'b1;
			{idex.mem_read, idex.mem_write, idex.reg_write, idex.ecall} <=
				{mem_read, mem_write, reg_write, ecall};
		end
		idex.pc <= ifid_pc;
		idex.rs1_data <= op1;
		idex.rs2_data <= op2;
		idex.imm <= imm;
		idex.rs1 <= rs1;
		idex.rs2 <= rs2;
		idex.rd <= ins.r.rd;
		idex.alu_op <= alu_op;
		{idex.use_imm, idex.use_pc, idex.link} <= {use_imm, use_pc, link};
	end
endmodule

//--- hw/execute.sv
module execute (
	input logic clk,
	input logic reset,
	input logic debug,
	input logic wb_we,
	input logic [4:0] wb_rd,
	input logic [31:0] wb_data,
	idex_if.dst idex,
	exmem_if.src exmem
);
	logic [31:0] a_fwd, b_fwd, a, b, result;

	function automatic logic [31:0] fwd(input logic [4:0] r, input logic [31:0] data);
		if (r == 5'd0) return data;
		// Loads in EX/MEM never reach here, the hazard unit holds their users
		if (exmem.valid && exmem.reg_write && !exmem.mem_read && exmem.rd == r)
			return exmem.result;
		if (wb_we && wb_rd == r) return wb_data;
		return data;
	endfunction

	always_comb begin
		a_fwd = fwd(idex.rs1, idex.rs1_data);
		b_fwd = fwd(idex.rs2, idex.rs2_data);
		a = idex.use_pc ? idex.pc : a_fwd;
		b = idex.link ? 32'd4 : (idex.use_imm ? idex.imm : b_fwd);
		case (idex.alu_op)
			cpu_pkg::alu_sub: result = a - b;
			cpu_pkg::alu_and: result = a & b;
			cpu_pkg::alu_or: result = a | b;
			cpu_pkg::alu_xor: result = a ^ b;
			cpu_pkg::alu_slt: result = {31'd0, $signed(a) < $signed(b)};
			cpu_pkg::alu_pass_b: result = b;
			default: result = a + b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset || debug || !idex.valid) begin
			exmem.valid <= 1'b0;
			{exmem.mem_read, exmem.mem_write, exmem.reg_write, exmem.ecall} <= '0;
		end else begin
			exmem.valid <= 1'b1;
			{exmem.mem_read, exmem.mem_write, exmem.reg_write, exmem.ecall} <=
				{idex.mem_read, idex.mem_write, idex.reg_write, idex.ecall};
		end
		exmem.result <= result;
		exmem.store_data <= b_fwd;
		exmem.rs2 <= idex.rs2;
		exmem.rd <= idex.rd;
	end
endmodule

//--- hw/fetch.sv
module fetch (
	input logic clk,
	input logic reset,
	input logic debug,
	input logic stall,
	input logic flush_ifid,
	input logic fetch_stop,
	input logic take_branch,
	input logic [31:0] branch_pc,
	input logic [31:0] boot_addr,
	input logic [31:0] boot_data,
	output logic [31:0] ifid_pc,
	output logic [31:0] ifid_instr,
	output logic [31:0] fetch_instr
);
	logic [31:0] pc;
	logic stopped;
	logic redirect;
	logic [31:0] imem [mem_map_pkg::imem_words];

	assign redirect = take_branch && !stall;
	assign fetch_instr = imem[pc[mem_map_pkg::imem_index_bits+1:2]];

	// Boot words below the data base land here
	always_ff @(posedge clk) begin
		if (debug && boot_addr < mem_map_pkg::dmem_base) begin
			imem[boot_addr[mem_map_pkg::imem_index_bits+1:2]] <= boot_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || debug) begin
			pc <= '0;
			stopped <= 1'b0;
		end else begin
			if (redirect) begin
				pc <= branch_pc;
			end else if (!stall && !fetch_stop) begin
				pc <= pc + 32'd4;
			end
			// ECALL has entered IF/ID, only nops follow
			if (fetch_stop && !stall && !take_branch) begin
				stopped <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset || debug) begin
			ifid_pc <= '0;
			ifid_instr <= cpu_pkg::nop_word;
		end else if (flush_ifid) begin
			ifid_instr <= cpu_pkg::nop_word;
		end else if (!stall) begin
			ifid_pc <= pc;
			ifid_instr <= stopped ? cpu_pkg::nop_word : fetch_instr;
		end
	end

	pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);
endmodule

//--- hw/hazard_unit.sv
module hazard_unit (
	input logic [31:0] fetch_instr,
	input logic [4:0] rs1,
	input logic [4:0] rs2,
	input logic is_branch,
	input logic take_branch,
	idex_if.dst idex,
	output logic stall,
	output logic flush_ifid,
	output logic fetch_stop
);
	cpu_pkg::instr_u fetched;
	logic rd_match, load_use, branch_use;

	assign fetched = fetch_instr;
	assign rd_match = idex.valid && idex.rd != 5'd0 && (idex.rd == rs1 || idex.rd == rs2);

	// Decode compares branch operands, so any pending EX result waits
	assign load_use = rd_match && idex.mem_read;
	assign branch_use = rd_match && idex.reg_write && is_branch;

	assign stall = load_use || branch_use;
	assign flush_ifid = take_branch && !stall;
	assign fetch_stop = fetched.i.opcode == cpu_pkg::op_system;
endmodule

//--- hw/mem_map_pkg.sv
package mem_map_pkg;
	localparam int imem_words = 256;
	localparam int imem_index_bits = $clog2(imem_words);
	localparam int dmem_words = 256;
	localparam int dmem_index_bits = $clog2(dmem_words);
	localparam logic [31:0] dmem_base = 32'h0000_4000;
	localparam int io_lsb = 15;

	// Any set bit from io_lsb upward selects I/O
	function automatic logic io_region(input logic [31:0] addr);
		return |addr[31:io_lsb];
	endfunction
endpackage

//--- hw/memory.sv
module memory (
	input logic clk,
	input logic reset,
	input logic debug,
	input logic [31:0] boot_addr,
	input logic [31:0] boot_data,
	input logic [31:0] joystick_data,
	exmem_if.dst exmem,
	output logic wb_we,
	output logic [4:0] wb_rd,
	output logic [31:0] wb_data,
	output logic [31:0] exmem_result,
	output logic [4:0] exmem_rd,
	output logic exmem_reg_write,
	output logic io_store,
	output logic [31:0] mem_mapped_addr,
	output logic [31:0] mem_mapped_data_out,
	output logic halt
);
	logic [31:0] dmem [mem_map_pkg::dmem_words];
	logic [31:0] boot_off, data_off, rdata, store_data;
	logic is_io, dm_we;

	assign boot_off = boot_addr - mem_map_pkg::dmem_base;
	assign data_off = exmem.result - mem_map_pkg::dmem_base;
	assign is_io = mem_map_pkg::io_region(exmem.result);
	assign dm_we = exmem.mem_write && !is_io;
	assign io_store = exmem.mem_write && is_io;

	// Load just ahead in WB supplies the store word
	assign store_data = (wb_we && wb_rd != 5'd0 && wb_rd == exmem.rs2) ? wb_data : exmem.store_data;
	assign mem_mapped_addr = io_store ? exmem.result : '0;
	assign mem_mapped_data_out = io_store ? store_data : '0;

	always_ff @(posedge clk) begin
		if (debug && boot_addr >= mem_map_pkg::dmem_base) begin
			dmem[boot_off[mem_map_pkg::dmem_index_bits+1:2]] <= boot_data;
		end else if (dm_we) begin
			dmem[data_off[mem_map_pkg::dmem_index_bits+1:2]] <= store_data;
		end
	end

	assign rdata = is_io ? joystick_data : dmem[data_off[mem_map_pkg::dmem_index_bits+1:2]];

	// Load data is forwarded to decode as well
	assign exmem_result = exmem.mem_read ? rdata : exmem.result;
	assign exmem_rd = exmem.rd;
	assign exmem_reg_write = exmem.valid && exmem.reg_write;

	always_ff @(posedge clk) begin
		if (reset || debug) begin
			wb_we <= 1'b0;
			halt <= 1'b0;
		end else begin
			wb_we <= exmem_reg_write;
			if (exmem.valid && exmem.ecall) halt <= 1'b1;
		end
		wb_rd <= exmem.rd;
		wb_data <= exmem_result;
	end

	// Data accesses stay inside data memory
	dmem_in_range: assert property (@(posedge clk) disable iff (reset)
		exmem.valid && (exmem.mem_read || exmem.mem_write) && !is_io
		|-> data_off < mem_map_pkg::dmem_words * 4);
endmodule

//--- hw/stage_ifs.sv
interface idex_if;
	logic valid;
	logic [cpu_pkg::xlen-1:0] pc;
	logic [cpu_pkg::xlen-1:0] rs1_data;
	logic [cpu_pkg::xlen-1:0] rs2_data;
	logic [cpu_pkg::xlen-1:0] imm;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] rd;
	logic [3:0] alu_op;
	logic use_imm;
	logic use_pc;
	logic link;
	logic mem_read;
	logic mem_write;
	logic reg_write;
	logic ecall;

	modport src(output valid, pc, rs1_data, rs2_data, imm, rs1, rs2, rd, alu_op, use_imm,
		use_pc, link, mem_read, mem_write, reg_write, ecall);
	modport dst(input valid, pc, rs1_data, rs2_data, imm, rs1, rs2, rd, alu_op, use_imm,
		use_pc, link, mem_read, mem_write, reg_write, ecall);
endinterface

interface exmem_if;
	logic valid;
	logic [cpu_pkg::xlen-1:0] result;
	logic [cpu_pkg::xlen-1:0] store_data;
	logic [4:0] rs2;
	logic [4:0] rd;
	logic mem_read;
	logic mem_write;
	logic reg_write;
	logic ecall;

	modport src(output valid, result, store_data, rs2, rd, mem_read, mem_write, reg_write, ecall);
	modport dst(input valid, result, store_data, rs2, rd, mem_read, mem_write, reg_write, ecall);
endinterface

//--- tests/cpu_tb_prog.svh
`ifndef cpu_tb_prog_svh
`define cpu_tb_prog_svh

function automatic logic [31:0] r_type(input logic [2:0] f3, input logic [6:0] f7,
	input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
	cpu_pkg::instr_u w;
	w.r = '{f7, rs2, rs1, f3, rd, cpu_pkg::op_reg};
	return w;
endfunction

function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
	input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
	cpu_pkg::instr_u w;
	w.i = '{imm, rs1, f3, rd, op};
	return w;
endfunction

function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
	input logic [11:0] imm);
	cpu_pkg::instr_u w;
	w.s = '{imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_pkg::op_store};
	return w;
endfunction

function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
	input logic [4:0] rs2, input logic [12:0] imm);
	cpu_pkg::instr_u w;
	w.b = '{imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpu_pkg::op_branch};
	return w;
endfunction

function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
	cpu_pkg::instr_u w;
	w.u = '{imm, rd, cpu_pkg::op_lui};
	return w;
endfunction

function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
	cpu_pkg::instr_u w;
	w.j = '{imm[20], imm[10:1], imm[11], imm[19:12], rd, cpu_pkg::op_jal};
	return w;
endfunction

task automatic emit(input logic [31:0] word);
	prog[prog_len] = word;
	prog_len++;
endtask

task automatic build_program();
	data_words[0] = 32'h1357_9bdf;
	data_words[1] = 32'h2468_ace0;
	// x10 is the I/O base, x11 the data memory base
	emit(u_type(5'd10, 20'h00010));
	emit(u_type(5'd11, 20'h00004));
	// Back-to-back dependent chain
	emit(i_type(cpu_pkg::op_imm, cpu_pkg::f3_add_sub, 5'd1, 5'd0, 12'h123));
	emit(i_type(cpu_pkg::op_imm, cpu_pkg::f3_xor, 5'd2, 5'd1, 12'h8f0));
	emit(r_type(cpu_pkg::f3_add_sub, 7'd0, 5'd3, 5'd2, 5'd1));
	emit(r_type(cpu_pkg::f3_add_sub, cpu_pkg::f7_sub, 5'd4, 5'd3, 5'd2));
	emit(r_type(cpu_pkg::f3_or, 7'd0, 5'd5, 5'd4, 5'd3));
	emit(r_type(cpu_pkg::f3_and, 7'd0, 5'd6, 5'd5, 5'd2));
	emit(i_type(cpu_pkg::op_imm, cpu_pkg::f3_or, 5'd7, 5'd6, 12'h00c));
	emit(i_type(cpu_pkg::op_imm, cpu_pkg::f3_and, 5'd8, 5'd7, 12'h7fe));
	emit(r_type(cpu_pkg::f3_slt, 7'd0, 5'd9, 5'd2, 5'd8));
	emit(s_type(5'd9, 5'd10, 12'h000));
	emit(s_type(5'd8, 5'd10, 12'h004));
	// Store, load back, use at once
	emit(s_type(5'd5, 5'd11, 12'h008));
	emit(i_type(cpu_pkg::op_load, 3'b010, 5'd12, 5'd11, 12'h008));
	emit(r_type(cpu_pkg::f3_add_sub, 7'd0, 5'd13, 5'd12, 5'd1));
	emit(s_type(5'd13, 5'd10, 12'h008));
	// Boot data word goes straight out
	emit(i_type(cpu_pkg::op_load, 3'b010, 5'd14, 5'd11, 12'h004));
	emit(s_type(5'd14, 5'd10, 12'h00c));
	// Five passes, the store after BNE is flushed while the loop runs
	emit(i_type(cpu_pkg::op_imm, cpu_pkg::f3_add_sub, 5'd15, 5'd0, 12'h005));
	emit(i_type(cpu_pkg::op_imm, cpu_pkg::f3_add_sub, 5'd16, 5'd0, 12'h000));
	emit(i_type(cpu_pkg::op_imm, cpu_pkg::f3_add_sub, 5'd16, 5'd16, 12'h007));
	emit(i_type(cpu_pkg::op_imm, cpu_pkg::f3_add_sub, 5'd15, 5'd15, 12'hfff));
	emit(b_type(cpu_pkg::f3_bne, 5'd15, 5'd0, 13'h1ff8));
	emit(s_type(5'd16, 5'd10, 12'h010));
	emit(b_type(cpu_pkg::f3_beq, 5'd15, 5'd16, 13'h0008));
	emit(s_type(5'd15, 5'd10, 12'h014));
	// Store in the JAL shadow must never show up
	emit(j_type(5'd17, 21'h000008));
	emit(s_type(5'd0, 5'd10, 12'h018));
	emit(s_type(5'd17, 5'd10, 12'h018));
	// Joystick read
	emit(i_type(cpu_pkg::op_load, 3'b010, 5'd18, 5'd10, 12'h000));
	emit(i_type(cpu_pkg::op_imm, cpu_pkg::f3_xor, 5'd19, 5'd18, 12'h5a5));
	emit(s_type(5'd19, 5'd10, 12'h01c));
	emit(i_type(cpu_pkg::op_system, 3'b000, 5'd0, 5'd0, 12'h000));
	// Store behind ECALL is never fetched
	emit(s_type(5'd1, 5'd10, 12'h020));
endtask

`endif

//--- tests/cpu_tb.sv
module cpu_tb;
	logic clk;
	logic reset;
	logic debug;
	logic [31:0] boot_addr;
	logic [31:0] boot_data;
	logic [31:0] joystick_data;
	logic [31:0] mem_mapped_addr;
	logic [31:0] mem_mapped_data_out;
	logic io_store;
	logic halt;
	logic [31:0] prog [mem_map_pkg::imem_words];
	logic [31:0] data_words [2];
	logic [31:0] exp_addr [16];
	logic [31:0] exp_data [16];
	int prog_len = 0;
	int n_exp = 0;
	int exp_idx = 0;
	integer seed = 32'h1e0e3788;

	`include "cpu_tb_prog.svh"

	cpu dut_i (
		.clk, .reset, .debug, .boot_addr, .boot_data, .joystick_data,
		.mem_mapped_addr, .mem_mapped_data_out, .io_store, .halt
	);

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		stop_with_error($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, got, want));
	endtask

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b010: return {31'd0, $signed(a) < $signed(b)};
			3'b100: return a ^ b;
			3'b110: return a | b;
			3'b111: return a & b;
			default: return sub ? a - b : a + b;
		endcase
	endfunction

	// In-order ISA model, fills the expected I/O store list
	task automatic run_model();
		cpu_pkg::instr_u w;
		logic [31:0] x [32];
		logic [31:0] dm [mem_map_pkg::dmem_words];
		logic [31:0] pc, next_pc, imm_i, addr, off;
		logic done;
		x = '{default: '0};
		dm = '{default: '0};
		pc = '0;
		done = 1'b0;
		for (int k = 0; k < 2; k++) dm[k] = data_words[k];
		for (int step = 0; step < 1000 && !done; step++) begin
			w = prog[pc[9:2]];
			imm_i = {{20{w.i.imm_11_0[11]}}, w.i.imm_11_0};
			addr = x[w.i.rs1] + imm_i;
			next_pc = pc + 32'd4;
			case (w.r.opcode)
				cpu_pkg::op_reg: begin
					x[w.r.rd] = alu_ref(w.r.funct3, w.r.funct7[5], x[w.r.rs1], x[w.r.rs2]);
				end
				cpu_pkg::op_imm: x[w.i.rd] = alu_ref(w.i.funct3, 1'b0, x[w.i.rs1], imm_i);
				cpu_pkg::op_lui: x[w.u.rd] = {w.u.imm_31_12, 12'd0};
				cpu_pkg::op_load: begin
					off = addr - mem_map_pkg::dmem_base;
					x[w.i.rd] = |addr[31:15] ? joystick_data : dm[off[9:2]];
				end
				cpu_pkg::op_store: begin
					addr = x[w.s.rs1] + {{20{w.s.imm_11_5[6]}}, w.s.imm_11_5, w.s.imm_4_0};
					off = addr - mem_map_pkg::dmem_base;
					if (|addr[31:15]) begin
						exp_addr[n_exp] = addr;
						exp_data[n_exp] = x[w.s.rs2];
						n_exp++;
					end else begin
						dm[off[9:2]] = x[w.s.rs2];
					end
				end
				cpu_pkg::op_branch: begin
					// funct3 bit 0 set means BNE
					if ((x[w.b.rs1] == x[w.b.rs2]) != w.b.funct3[0])
						next_pc = pc + {{20{w.b.imm_12}}, w.b.imm_11, w.b.imm_10_5, w.b.imm_4_1, 1'b0};
				end
				cpu_pkg::op_jal: begin
					x[w.j.rd] = pc + 32'd4;
					next_pc = pc + {{12{w.j.imm_20}}, w.j.imm_19_12, w.j.imm_11, w.j.imm_10_1, 1'b0};
				end
				default: done = 1'b1;
			endcase
			x[0] = '0;
			pc = next_pc;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		if (reset) exp_idx <= 0;
		else if (io_store) exp_idx <= exp_idx + 1;
	end

	boot_quiet: assert property (@(posedge clk) disable iff (reset) debug |-> !io_store && !halt)
		else stop_with_error("io_store or halt went high during boot");
	store_expected: assert property (@(posedge clk) disable iff (reset) io_store |-> exp_idx < n_exp)
		else stop_with_error("io_store seen after all expected stores");
	store_addr: assert property (@(posedge clk) disable iff (reset)
		io_store && exp_idx < n_exp |-> mem_mapped_addr == exp_addr[exp_idx])
		else report_mismatch("mem_mapped_addr", $sampled(mem_mapped_addr),
			exp_addr[$sampled(exp_idx)]);
	store_data: assert property (@(posedge clk) disable iff (reset)
		io_store && exp_idx < n_exp |-> mem_mapped_data_out == exp_data[exp_idx])
		else report_mismatch("mem_mapped_data_out", $sampled(mem_mapped_data_out),
			exp_data[$sampled(exp_idx)]);
	// I/O outputs read zero outside an I/O store
	idle_addr: assert property (@(posedge clk) disable iff (reset)
		!io_store |-> mem_mapped_addr == '0)
		else report_mismatch("mem_mapped_addr", $sampled(mem_mapped_addr), '0);
	idle_data: assert property (@(posedge clk) disable iff (reset)
		!io_store |-> mem_mapped_data_out == '0)
		else report_mismatch("mem_mapped_data_out", $sampled(mem_mapped_data_out), '0);
	halt_complete: assert property (@(posedge clk) disable iff (reset) $rose(halt) |-> exp_idx == n_exp)
		else stop_with_error("halt rose before all expected stores were seen");
	halt_quiet: assert property (@(posedge clk) disable iff (reset) halt |-> !io_store)
		else stop_with_error("io_store seen after halt");
	halt_held: assert property (@(posedge clk) disable iff (reset) halt |=> halt)
		else stop_with_error("halt dropped before the end of the run");

	// Watchdog starts once boot is over
	initial begin
		wait (reset === 1'b0 && debug === 1'b0);
		#((prog_len * 4 + 200) * 4);
		stop_with_error("timeout waiting for halt");
	end

	initial begin
		reset = 1'b1;
		debug = 1'b1;
		boot_addr = '0;
		boot_data = '0;
		joystick_data = '0;
		build_program();
		joystick_data = $random(seed);
		run_model();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int k = 0; k < prog_len; k++) begin
			boot_addr = 32'(k * 4);
			boot_data = prog[k];
			@(posedge clk);
			#1;
		end
		for (int k = 0; k < 2; k++) begin
			boot_addr = mem_map_pkg::dmem_base + 32'(k * 4);
			boot_data = data_words[k];
			@(posedge clk);
			#1;
		end
		debug = 1'b0;
		wait (halt === 1'b1);
		repeat (8) @(posedge clk);
		if (exp_idx != n_exp || halt !== 1'b1) begin
			stop_with_error("run ended with missing stores or halt low");
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end
endmodule
